// File: src/mipsPkg.sv
`default_nettype none

package mipsPkg;

    localparam int wordWidth = 32;
    localparam int regAddrWidth = 5;

    typedef logic [wordWidth-1:0] wordT;
    typedef logic [regAddrWidth-1:0] regAddrT;

    // Every bus transfer is a full aligned word
    localparam logic [3:0] allByteEnable = 4'b1111;

    typedef enum logic [2:0] {
        FETCH, DECODE, EXECUTE, MEMORY, WRITEBACK, HALT
    } stateT;

    // Primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'd0, OP_J = 6'd2, OP_BEQ = 6'd4, OP_BNE = 6'd5,
        OP_ADDIU = 6'd9, OP_SLTI = 6'd10, OP_SLTIU = 6'd11, OP_ANDI = 6'd12,
        OP_ORI = 6'd13, OP_XORI = 6'd14, OP_LUI = 6'd15,
        OP_LW = 6'd35, OP_SW = 6'd43
    } opcodeT;

    // Function field of SPECIAL, bits 5:0
    typedef enum logic [5:0] {
        FN_SLL = 6'd0, FN_SRL = 6'd2, FN_SRA = 6'd3, FN_JR = 6'd8,
        FN_ADDU = 6'd33, FN_SUBU = 6'd35, FN_AND = 6'd36, FN_OR = 6'd37,
        FN_XOR = 6'd38, FN_SLT = 6'd42, FN_SLTU = 6'd43
    } functT;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI, ALU_PASS_B
    } aluOpT;

    typedef enum logic [2:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_JUMP, BR_JUMP_REG
    } branchOpT;

endpackage

`default_nettype wire

// File: src/mipsAlu.sv
`timescale 1ns/1ps
`default_nettype none

module mipsAlu (
    input  mipsPkg::aluOpT aluOp,
    input  mipsPkg::wordT  operandA,
    input  mipsPkg::wordT  operandB,
    input  wire logic [4:0] shamt,
    output mipsPkg::wordT  result
);

    logic signedLess;
    logic unsignedLess;

    assign signedLess   = $signed(operandA) < $signed(operandB);
    assign unsignedLess = operandA < operandB;

    always_comb begin
        case (aluOp)
            mipsPkg::ALU_ADD: begin
                result = operandA + operandB;
            end
            mipsPkg::ALU_SUB: begin
                result = operandA - operandB;
            end
            mipsPkg::ALU_AND: begin
                result = operandA & operandB;
            end
            mipsPkg::ALU_OR: begin
                result = operandA | operandB;
            end
            mipsPkg::ALU_XOR: begin
                result = operandA ^ operandB;
            end
            mipsPkg::ALU_SLT: begin
                result = {31'b0, signedLess};
            end
            mipsPkg::ALU_SLTU: begin
                result = {31'b0, unsignedLess};
            end
            // Fixed shifts act on the rt operand
            mipsPkg::ALU_SLL: begin
                result = operandB << shamt;
            end
            mipsPkg::ALU_SRL: begin
                result = operandB >> shamt;
            end
            mipsPkg::ALU_SRA: begin
                result = $unsigned($signed(operandB) >>> shamt);
            end
            mipsPkg::ALU_LUI: begin
                result = {operandB[15:0], 16'b0};
            end
            default: begin
                result = operandB;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/mipsBranchUnit.sv
`timescale 1ns/1ps
`default_nettype none

module mipsBranchUnit (
    input  mipsPkg::branchOpT branchOp,
    input  mipsPkg::wordT     pc,
    input  mipsPkg::wordT     rsValue,
    input  mipsPkg::wordT     rtValue,
    input  wire logic [15:0]  immediate,
    input  wire logic [25:0]  jumpIndex,
    output logic              taken,
    output mipsPkg::wordT     target
);

    mipsPkg::wordT pcPlusFour;
    mipsPkg::wordT branchDest;
    mipsPkg::wordT jumpDest;

    assign pcPlusFour = pc + 32'd4;
    // Word offset, sign extended
    assign branchDest = pcPlusFour + {{14{immediate[15]}}, immediate, 2'b00};
    // Stays in the current 256 MB region
    assign jumpDest   = {pcPlusFour[31:28], jumpIndex, 2'b00};

    always_comb begin
        taken  = 1'b0;
        target = pcPlusFour;
        case (branchOp)
            mipsPkg::BR_BEQ: begin
                taken  = (rsValue == rtValue);
                target = branchDest;
            end
            mipsPkg::BR_BNE: begin
                taken  = (rsValue != rtValue);
                target = branchDest;
            end
            mipsPkg::BR_JUMP: begin
                taken  = 1'b1;
                target = jumpDest;
            end
            mipsPkg::BR_JUMP_REG: begin
                taken  = 1'b1;
                target = rsValue;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: src/mipsRegFile.sv
`timescale 1ns/1ps
`default_nettype none

module mipsRegFile (
    input  wire logic         clk,
    input  wire logic         reset,
    input  mipsPkg::regAddrT  rsAddr,
    input  mipsPkg::regAddrT  rtAddr,
    output mipsPkg::wordT     rsData,
    output mipsPkg::wordT     rtData,
    input  wire logic         writeEnable,
    input  mipsPkg::regAddrT  writeAddr,
    input  mipsPkg::wordT     writeData,
    output mipsPkg::wordT     registerV0
);

    mipsPkg::wordT regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Register zero is hardwired
    assign rsData = (rsAddr == '0) ? '0 : regs[rsAddr];
    assign rtData = (rtAddr == '0) ? '0 : regs[rtAddr];

    // v0 for the outside world
    assign registerV0 = regs[2];

endmodule

`default_nettype wire

// File: src/mipsControl.sv
`timescale 1ns/1ps
`default_nettype none

module mipsControl #(
    parameter mipsPkg::wordT resetVector = 32'hBFC00000
) (
    input  wire logic             clk,
    input  wire logic             reset,
    output mipsPkg::wordT         address,
    output logic                  read,
    output logic                  write,
    output mipsPkg::wordT         writedata,
    output logic [3:0]            byteenable,
    input  wire logic             waitrequest,
    input  mipsPkg::wordT         readdata,
    output logic                  active,
    output mipsPkg::regAddrT      rsAddr,
    output mipsPkg::regAddrT      rtAddr,
    input  mipsPkg::wordT         rsData,
    input  mipsPkg::wordT         rtData,
    output logic                  regWrite,
    output mipsPkg::regAddrT      regWriteAddr,
    output mipsPkg::wordT         regWriteData,
    output mipsPkg::aluOpT        aluOp,
    output mipsPkg::wordT         operandA,
    output mipsPkg::wordT         operandB,
    output logic [4:0]            shamt,
    input  mipsPkg::wordT         aluResult,
    output mipsPkg::branchOpT     branchOp,
    output mipsPkg::wordT         pc,
    output logic [15:0]           immediate,
    output logic [25:0]           jumpIndex,
    input  wire logic             branchTaken,
    input  mipsPkg::wordT         branchTarget
);

    mipsPkg::stateT  state;
    mipsPkg::wordT   pcReg;
    mipsPkg::wordT   instrReg;
    mipsPkg::wordT   aluOut;
    mipsPkg::wordT   loadData;
    mipsPkg::opcodeT opcode;
    mipsPkg::functT  funct;
    mipsPkg::wordT   immExt;
    logic            useImm;
    logic            zeroExtend;
    logic            destIsRd;
    logic            isLoad;
    logic            isStore;
    logic            legal;

    // Instruction fields
    assign opcode    = mipsPkg::opcodeT'(instrReg[31:26]);
    assign funct     = mipsPkg::functT'(instrReg[5:0]);
    assign rsAddr    = instrReg[25:21];
    assign rtAddr    = instrReg[20:16];
    assign shamt     = instrReg[10:6];
    assign immediate = instrReg[15:0];
    assign jumpIndex = instrReg[25:0];
    assign pc        = pcReg;

    always_comb begin
        aluOp      = mipsPkg::ALU_PASS_B;
        branchOp   = mipsPkg::BR_NONE;
        useImm     = 1'b1;
        zeroExtend = 1'b0;
        destIsRd   = 1'b0;
        isLoad     = 1'b0;
        isStore    = 1'b0;
        legal      = 1'b1;
        case (opcode)
            mipsPkg::OP_SPECIAL: begin
                useImm   = 1'b0;
                destIsRd = 1'b1;
                case (funct)
                    mipsPkg::FN_SLL:  aluOp = mipsPkg::ALU_SLL;
                    mipsPkg::FN_SRL:  aluOp = mipsPkg::ALU_SRL;
                    mipsPkg::FN_SRA:  aluOp = mipsPkg::ALU_SRA;
                    mipsPkg::FN_JR:   branchOp = mipsPkg::BR_JUMP_REG;
                    mipsPkg::FN_ADDU: aluOp = mipsPkg::ALU_ADD;
                    mipsPkg::FN_SUBU: aluOp = mipsPkg::ALU_SUB;
                    mipsPkg::FN_AND:  aluOp = mipsPkg::ALU_AND;
                    mipsPkg::FN_OR:   aluOp = mipsPkg::ALU_OR;
                    mipsPkg::FN_XOR:  aluOp = mipsPkg::ALU_XOR;
                    mipsPkg::FN_SLT:  aluOp = mipsPkg::ALU_SLT;
                    mipsPkg::FN_SLTU: aluOp = mipsPkg::ALU_SLTU;
                    default:          legal = 1'b0;
                endcase
            end
            mipsPkg::OP_J:     branchOp = mipsPkg::BR_JUMP;
            mipsPkg::OP_BEQ:   branchOp = mipsPkg::BR_BEQ;
            mipsPkg::OP_BNE:   branchOp = mipsPkg::BR_BNE;
            mipsPkg::OP_ADDIU: aluOp = mipsPkg::ALU_ADD;
            mipsPkg::OP_SLTI:  aluOp = mipsPkg::ALU_SLT;
            mipsPkg::OP_SLTIU: aluOp = mipsPkg::ALU_SLTU;
            mipsPkg::OP_ANDI: begin
                aluOp      = mipsPkg::ALU_AND;
                zeroExtend = 1'b1;
            end
            mipsPkg::OP_ORI: begin
                aluOp      = mipsPkg::ALU_OR;
                zeroExtend = 1'b1;
            end
            mipsPkg::OP_XORI: begin
                aluOp      = mipsPkg::ALU_XOR;
                zeroExtend = 1'b1;
            end
            mipsPkg::OP_LUI:   aluOp = mipsPkg::ALU_LUI;
            // Effective address rs plus signed offset
            mipsPkg::OP_LW: begin
                aluOp  = mipsPkg::ALU_ADD;
                isLoad = 1'b1;
            end
            mipsPkg::OP_SW: begin
                aluOp   = mipsPkg::ALU_ADD;
                isStore = 1'b1;
            end
            default: legal = 1'b0;
        endcase
    end

    assign immExt   = zeroExtend ? {16'b0, immediate} : {{16{immediate[15]}}, immediate};
    assign operandA = rsData;
    assign operandB = useImm ? immExt : rtData;

    // Writeback from rd or rt, load data or ALU result
    assign regWrite     = (state == mipsPkg::WRITEBACK);
    assign regWriteAddr = destIsRd ? instrReg[15:11] : rtAddr;
    assign regWriteData = isLoad ? loadData : aluOut;

    // Bus master, strobes follow the state directly
    assign writedata  = rtData;
    assign byteenable = mipsPkg::allByteEnable;

    always_comb begin
        read    = 1'b0;
        write   = 1'b0;
        address = pcReg;
        case (state)
            mipsPkg::FETCH: read = 1'b1;
            mipsPkg::MEMORY: begin
                address = aluOut;
                read    = isLoad;
                write   = isStore;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            // Park in HALT with active high until reset is released
            state  <= mipsPkg::HALT;
            active <= 1'b1;
            pcReg  <= resetVector;
        end else begin
            case (state)
                mipsPkg::FETCH: begin
                    if (!waitrequest) begin
                        instrReg <= readdata;
                        state    <= mipsPkg::DECODE;
                    end
                end
                mipsPkg::DECODE: begin
                    if (legal) begin
                        state <= mipsPkg::EXECUTE;
                    end else begin
                        state  <= mipsPkg::HALT;
                        active <= 1'b0;
                    end
                end
                mipsPkg::EXECUTE: begin
                    aluOut <= aluResult;
                    pcReg  <= branchTaken ? branchTarget : pcReg + 32'd4;
                    if (branchOp == mipsPkg::BR_JUMP_REG && branchTarget == '0) begin
                        state  <= mipsPkg::HALT;
                        active <= 1'b0;
                    end else if (branchOp != mipsPkg::BR_NONE) begin
                        state <= mipsPkg::FETCH;
                    end else if (isLoad || isStore) begin
                        state <= mipsPkg::MEMORY;
                    end else begin
                        state <= mipsPkg::WRITEBACK;
                    end
                end
                mipsPkg::MEMORY: begin
                    if (!waitrequest) begin
                        loadData <= readdata;
                        state    <= isLoad ? mipsPkg::WRITEBACK : mipsPkg::FETCH;
                    end
                end
                mipsPkg::WRITEBACK: state <= mipsPkg::FETCH;
                mipsPkg::HALT: begin
                    // Only the post-reset park still has active set
                    if (active) begin
                        state <= mipsPkg::FETCH;
                    end
                end
                default: state <= mipsPkg::HALT;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/mipsCpu.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCpu #(
    parameter mipsPkg::wordT resetVector = 32'hBFC00000
) (
    input  wire logic          clk,
    input  wire logic          reset,
    output logic               active,
    output mipsPkg::wordT      registerV0,
    output mipsPkg::wordT      address,
    output logic               write,
    output logic               read,
    input  wire logic          waitrequest,
    output mipsPkg::wordT      writedata,
    output logic [3:0]         byteenable,
    input  mipsPkg::wordT      readdata
);

    mipsPkg::regAddrT  rsAddr;
    mipsPkg::regAddrT  rtAddr;
    mipsPkg::wordT     rsData;
    mipsPkg::wordT     rtData;
    logic              regWrite;
    mipsPkg::regAddrT  regWriteAddr;
    mipsPkg::wordT     regWriteData;
    mipsPkg::aluOpT    aluOp;
    mipsPkg::wordT     operandA;
    mipsPkg::wordT     operandB;
    logic [4:0]        shamt;
    mipsPkg::wordT     aluResult;
    mipsPkg::branchOpT branchOp;
    mipsPkg::wordT     pc;
    logic [15:0]       immediate;
    logic [25:0]       jumpIndex;
    logic              branchTaken;
    mipsPkg::wordT     branchTarget;

    mipsControl #(
        .resetVector(resetVector)
    ) u_control (
        .clk(clk), .reset(reset),
        .address(address), .read(read), .write(write), .writedata(writedata),
        .byteenable(byteenable), .waitrequest(waitrequest), .readdata(readdata),
        .active(active),
        .rsAddr(rsAddr), .rtAddr(rtAddr), .rsData(rsData), .rtData(rtData),
        .regWrite(regWrite), .regWriteAddr(regWriteAddr), .regWriteData(regWriteData),
        .aluOp(aluOp), .operandA(operandA), .operandB(operandB), .shamt(shamt),
        .aluResult(aluResult),
        .branchOp(branchOp), .pc(pc), .immediate(immediate), .jumpIndex(jumpIndex),
        .branchTaken(branchTaken), .branchTarget(branchTarget)
    );

    mipsRegFile u_regFile (
        .clk(clk), .reset(reset),
        .rsAddr(rsAddr), .rtAddr(rtAddr), .rsData(rsData), .rtData(rtData),
        .writeEnable(regWrite), .writeAddr(regWriteAddr), .writeData(regWriteData),
        .registerV0(registerV0)
    );

    mipsAlu u_alu (
        .aluOp(aluOp), .operandA(operandA), .operandB(operandB), .shamt(shamt),
        .result(aluResult)
    );

    // Branch unit reads the register file directly
    mipsBranchUnit u_branchUnit (
        .branchOp(branchOp), .pc(pc), .rsValue(rsData), .rtValue(rtData),
        .immediate(immediate), .jumpIndex(jumpIndex),
        .taken(branchTaken), .target(branchTarget)
    );

endmodule

`default_nettype wire

// File: verif/mipsControl_chk.sv
`timescale 1ns/1ps
`default_nettype none

module mipsControl_chk (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic           read,
    input  wire logic           write,
    input  wire logic           waitrequest,
    input  wire logic           active,
    input  wire mipsPkg::wordT  address
);

    logic resetLastCycle;

    always_ff @(posedge clk) begin
        resetLastCycle <= reset;
    end

    // Only one strobe at a time
    strobesExclusive: assert property (@(posedge clk) !(read && write))
        else $error("read and write are high together");

    // Stalled transfer keeps its address and strobe
    addressHeld: assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=> $stable(address) && $stable(read) && $stable(write))
        else $error("address or strobe changed during a stall");

    // From the second reset edge on the bus is quiet
    quietInReset: assert property (@(posedge clk)
        reset && resetLastCycle |-> !read && !write)
        else $error("bus strobe high during reset");

    haltSticky: assert property (@(posedge clk) disable iff (reset) !active |=> !active)
        else $error("active rose again without a reset");

endmodule

bind mipsControl mipsControl_chk u_controlChk (
    .clk(clk), .reset(reset), .read(read), .write(write),
    .waitrequest(waitrequest), .active(active), .address(address)
);

`default_nettype wire

// File: verif/mipsCpuModel.svh
`ifndef MIPS_CPU_MODEL_SVH
`define MIPS_CPU_MODEL_SVH

// Instruction-level model of the kept subset, no delay slots
task automatic runModel();
    logic [31:0] regs [32];
    logic [31:0] pc;
    logic [31:0] instr;
    logic [31:0] rsVal;
    logic [31:0] rtVal;
    logic [31:0] immSext;
    logic [31:0] immZext;
    logic [31:0] result;
    logic [31:0] addr;
    logic [31:0] nextPc;
    logic [4:0]  dest;
    logic        doWrite;
    logic        halted;
    int          steps;
    for (int r = 0; r < 32; r++) begin
        regs[r] = '0;
    end
    expReads.delete();
    expWriteAddr.delete();
    expWriteData.delete();
    modelMem = dataMem;
    pc = codeBase;
    halted = 1'b0;
    steps = 0;
    while (!halted && steps < numInstr) begin
        expReads.push_back(pc);
        instr   = codeMem[wordIndex(pc, codeBase)];
        rsVal   = regs[instr[25:21]];
        rtVal   = regs[instr[20:16]];
        immSext = {{16{instr[15]}}, instr[15:0]};
        immZext = {16'b0, instr[15:0]};
        nextPc  = pc + 32'd4;
        dest    = instr[20:16];
        doWrite = 1'b1;
        result  = '0;
        case (instr[31:26])
            mipsPkg::OP_SPECIAL: begin
                dest = instr[15:11];
                case (instr[5:0])
                    mipsPkg::FN_ADDU: result = rsVal + rtVal;
                    mipsPkg::FN_SUBU: result = rsVal - rtVal;
                    mipsPkg::FN_AND:  result = rsVal & rtVal;
                    mipsPkg::FN_OR:   result = rsVal | rtVal;
                    mipsPkg::FN_XOR:  result = rsVal ^ rtVal;
                    mipsPkg::FN_SLT:  result = {31'b0, $signed(rsVal) < $signed(rtVal)};
                    mipsPkg::FN_SLTU: result = {31'b0, rsVal < rtVal};
                    mipsPkg::FN_SLL:  result = rtVal << instr[10:6];
                    mipsPkg::FN_SRL:  result = rtVal >> instr[10:6];
                    mipsPkg::FN_SRA:  result = $unsigned($signed(rtVal) >>> instr[10:6]);
                    mipsPkg::FN_JR: begin
                        doWrite = 1'b0;
                        nextPc  = rsVal;
                        halted  = (rsVal == '0);
                    end
                    default: begin
                        doWrite = 1'b0;
                        halted  = 1'b1;
                    end
                endcase
            end
            mipsPkg::OP_ADDIU: result = rsVal + immSext;
            mipsPkg::OP_SLTI:  result = {31'b0, $signed(rsVal) < $signed(immSext)};
            mipsPkg::OP_SLTIU: result = {31'b0, rsVal < immSext};
            mipsPkg::OP_ANDI:  result = rsVal & immZext;
            mipsPkg::OP_ORI:   result = rsVal | immZext;
            mipsPkg::OP_XORI:  result = rsVal ^ immZext;
            mipsPkg::OP_LUI:   result = {instr[15:0], 16'b0};
            mipsPkg::OP_LW: begin
                addr = rsVal + immSext;
                expReads.push_back(addr);
                result = modelMem[wordIndex(addr, dataBase)];
            end
            mipsPkg::OP_SW: begin
                doWrite = 1'b0;
                addr = rsVal + immSext;
                expWriteAddr.push_back(addr);
                expWriteData.push_back(rtVal);
                modelMem[wordIndex(addr, dataBase)] = rtVal;
            end
            mipsPkg::OP_BEQ, mipsPkg::OP_BNE: begin
                doWrite = 1'b0;
                if ((rsVal == rtVal) == (instr[31:26] == mipsPkg::OP_BEQ)) begin
                    nextPc = pc + 32'd4 + (immSext << 2);
                end
            end
            mipsPkg::OP_J: begin
                doWrite = 1'b0;
                nextPc  = {nextPc[31:28], instr[25:0], 2'b00};
            end
            default: begin
                doWrite = 1'b0;
                halted  = 1'b1;
            end
        endcase
        if (doWrite && dest != '0) begin
            regs[dest] = result;
        end
        pc = nextPc;
        steps++;
    end
    modelV0 = regs[2];
endtask

`endif

// File: verif/mipsCpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCpuTb;

    localparam logic [31:0] codeBase = 32'hBFC00000;
    localparam logic [31:0] dataBase = 32'h10008000;
    localparam int numPrograms = 20;
    localparam int numInstr = 64;
    localparam int dataWords = 64;
    localparam int resetCycles = 16;
    localparam int idleCycles = 20;
    // Five cycles per instruction at most and four times that for stalls
    localparam int cycleLimit = numPrograms * (numInstr * 5 * 4 + resetCycles + idleCycles);

    localparam logic [5:0] aluFuncts [10] = '{
        mipsPkg::FN_SLL, mipsPkg::FN_SRL, mipsPkg::FN_SRA, mipsPkg::FN_ADDU,
        mipsPkg::FN_SUBU, mipsPkg::FN_AND, mipsPkg::FN_OR, mipsPkg::FN_XOR,
        mipsPkg::FN_SLT, mipsPkg::FN_SLTU
    };
    localparam logic [5:0] immOps [7] = '{
        mipsPkg::OP_ADDIU, mipsPkg::OP_SLTI, mipsPkg::OP_SLTIU, mipsPkg::OP_ANDI,
        mipsPkg::OP_ORI, mipsPkg::OP_XORI, mipsPkg::OP_LUI
    };

    logic        clk;
    logic        reset;
    logic        active;
    logic [31:0] registerV0;
    logic [31:0] address;
    logic        write;
    logic        read;
    logic        waitrequest;
    logic [31:0] writedata;
    logic [3:0]  byteenable;
    logic [31:0] readdata;

    integer      seed = 32'h65ce1972;
    int          cycleCount = 0;
    logic        firstFetch = 1'b0;
    logic [31:0] codeMem [numInstr];
    logic [31:0] dataMem [dataWords];
    logic [31:0] modelMem [dataWords];
    logic [31:0] modelV0;
    logic [31:0] expReads [$];
    logic [31:0] expWriteAddr [$];
    logic [31:0] expWriteData [$];

    mipsCpu #(
        .resetVector(codeBase)
    ) u_mipsCpu (
        .clk(clk), .reset(reset), .active(active), .registerV0(registerV0),
        .address(address), .write(write), .read(read), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata)
    );

    `include "mipsCpuModel.svh"

    function automatic int randBelow(input int n);
        return int'($unsigned($random(seed)) % $unsigned(n));
    endfunction

    function automatic logic inRegion(input logic [31:0] addr, input logic [31:0] base,
                                      input int words);
        return (addr - base) < 32'(words * 4);
    endfunction

    function automatic int wordIndex(input logic [31:0] addr, input logic [31:0] base);
        logic [31:0] offset;
        offset = (addr - base) >> 2;
        return int'(offset[5:0]);
    endfunction

    function automatic logic [31:0] memRead(input logic [31:0] addr);
        if (inRegion(addr, codeBase, numInstr)) begin
            return codeMem[wordIndex(addr, codeBase)];
        end else if (inRegion(addr, dataBase, dataWords)) begin
            return dataMem[wordIndex(addr, dataBase)];
        end
        return '0;
    endfunction

    task automatic stopOnError(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic buildProgram();
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dest;
        logic [4:0]  sh;
        logic [5:0]  fn;
        logic [5:0]  opc;
        logic [31:0] jumpAddr;
        int          target;
        // Prologue puts the data base into register 8
        codeMem[0] = {mipsPkg::OP_LUI, 5'd0, 5'd8, dataBase[31:16]};
        codeMem[1] = {mipsPkg::OP_ORI, 5'd8, 5'd8, dataBase[15:0]};
        for (int i = 2; i < numInstr - 1; i++) begin
            rs = 5'(randBelow(32));
            rt = 5'(randBelow(32));
            dest = 5'(randBelow(32));
            if (dest == 5'd8) begin
                dest = 5'd9;
            end
            target = i + 1 + randBelow(numInstr - 1 - i);
            case (randBelow(10))
                0, 1, 2: begin
                    fn = aluFuncts[randBelow(10)];
                    sh = (fn < 6'd4) ? 5'(randBelow(32)) : 5'd0;
                    codeMem[i] = {6'd0, rs, rt, dest, sh, fn};
                end
                3, 4, 5: codeMem[i] = {immOps[randBelow(7)], rs, dest, 16'(randBelow(65536))};
                6: codeMem[i] = {mipsPkg::OP_LW, 5'd8, dest, 8'd0, 6'(randBelow(dataWords)), 2'b00};
                7: codeMem[i] = {mipsPkg::OP_SW, 5'd8, rt, 8'd0, 6'(randBelow(dataWords)), 2'b00};
                8: begin
                    opc = (randBelow(2) == 0) ? mipsPkg::OP_BEQ : mipsPkg::OP_BNE;
                    codeMem[i] = {opc, rs, rt, 16'(target - i - 1)};
                end
                default: begin
                    jumpAddr = codeBase + 32'(target * 4);
                    codeMem[i] = {mipsPkg::OP_J, jumpAddr[27:2]};
                end
            endcase
        end
        // JR through register zero ends the program
        codeMem[numInstr - 1] = {6'd0, 5'd0, 15'd0, mipsPkg::FN_JR};
        for (int w = 0; w < dataWords; w++) begin
            dataMem[w] = $random(seed);
        end
    endtask

    task automatic resetAndLoad();
        reset = 1'b1;
        firstFetch = 1'b1;
        @(posedge clk);
        #1;
        buildProgram();
        runModel();
        for (int c = 1; c < resetCycles; c++) begin
            @(posedge clk);
            #1;
            assert (!read && !write && active) else
                stopOnError($sformatf("mismatch at %0t: strobes or active wrong in reset", $time));
        end
        reset = 1'b0;
    endtask

    task automatic checkRead();
        logic [31:0] expected;
        assert (expReads.size() > 0) else
            stopOnError("Bus read seen after the model ran out of expected reads");
        expected = expReads.pop_front();
        assert (address == expected) else
            stopOnError($sformatf("mismatch at %0t: read address %h, expected %h",
                                  $time, address, expected));
    endtask

    task automatic checkWrite();
        logic [31:0] expAddr;
        logic [31:0] expData;
        assert (expWriteAddr.size() > 0) else
            stopOnError("Bus write seen that the model does not expect");
        expAddr = expWriteAddr.pop_front();
        expData = expWriteData.pop_front();
        assert (address == expAddr && writedata == expData && byteenable == 4'hF) else
            stopOnError($sformatf("mismatch at %0t: write %h=%h be %h, expected %h=%h",
                                  $time, address, writedata, byteenable, expAddr, expData));
        dataMem[wordIndex(address, dataBase)] = writedata;
    endtask

    task automatic checkHalt();
        logic [31:0] v0;
        assert (expReads.size() == 0 && expWriteAddr.size() == 0) else
            stopOnError("Core halted before all expected bus transfers were seen");
        assert (registerV0 == modelV0) else
            stopOnError($sformatf("mismatch at %0t: registerV0 %h, expected %h",
                                  $time, registerV0, modelV0));
        for (int w = 0; w < dataWords; w++) begin
            assert (dataMem[w] == modelMem[w]) else
                stopOnError($sformatf("mismatch at %0t: data word %0d is %h, expected %h",
                                      $time, w, dataMem[w], modelMem[w]));
        end
        v0 = registerV0;
        repeat (idleCycles) begin
            @(posedge clk);
            #1;
            assert (!read && !write && !active && registerV0 == v0) else
                stopOnError($sformatf("mismatch at %0t: core not quiet after halt", $time));
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin : watchdog
        forever begin
            @(posedge clk);
            cycleCount++;
            if (cycleCount > cycleLimit) begin
                $display("SIMULATION FAILED");
                $fatal(1, "Timeout: the core did not finish within %0d cycles", cycleLimit);
            end
        end
    end

    // Memory model that stalls only while a strobe is up
    initial begin : busMemory
        forever begin
            @(posedge clk);
            #1;
            waitrequest = (read || write) && (randBelow(4) == 0);
            readdata = read ? memRead(address) : '0;
            if (read && firstFetch) begin
                firstFetch = 1'b0;
                assert (address == codeBase) else
                    stopOnError($sformatf("mismatch at %0t: first fetch from %h", $time, address));
            end
            if (read && !waitrequest) begin
                checkRead();
            end
            if (write && !waitrequest) begin
                checkWrite();
            end
        end
    end

    initial begin
        reset = 1'b1;
        waitrequest = 1'b0;
        readdata = '0;
        for (int p = 0; p < numPrograms; p++) begin
            resetAndLoad();
            do begin
                @(posedge clk);
                #1;
            end while (active);
            checkHalt();
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: mipsCpu.f
+incdir+verif
src/mipsPkg.sv
src/mipsAlu.sv
src/mipsBranchUnit.sv
src/mipsRegFile.sv
src/mipsControl.sv
src/mipsCpu.sv
verif/mipsControl_chk.sv
verif/mipsCpuTb.sv

// File: Makefile
VERILATOR  := verilator
TOP        := mipsCpuTb
RTL_TOP    := mipsCpu
FILELIST   := mipsCpu.f
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_TEXT  := SIMULATION PASSED
RTL_FILES  := src/mipsPkg.sv src/mipsAlu.sv src/mipsBranchUnit.sv src/mipsRegFile.sv \
              src/mipsControl.sv src/mipsCpu.sv
SOURCES    := $(RTL_FILES) $(wildcard verif/*.sv verif/*.svh)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
